//--- all.f
src/pet_bus_pkg.sv
src/register_file.sv
src/wb_ram.sv
src/wb_address_decoder.sv
src/pet_bus_top.sv
sim/tb_pet_bus.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns --top-module tb_pet_bus -Mdir obj_dir -f all.f

./obj_dir/Vtb_pet_bus > sim.log 2>&1
cat sim.log

# The log decides the result
if grep -qx "All checks passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

//--- sim/bus_patterns.txt
# Columns (hex): op addr data gfx exp flags
# op W write, R read and compare, I idle for data cycles, P check pins
# P exp bits are {mask[1:0], col80, cpu_reset, cpu_ready}, RAM reads use the scoreboard
# flags bit 0 strobes the next line on the following cycle, bit 1 writes random data
# Power-on values
P 000 00 1 02 0
I 000 02 1 00 0
R 800 00 1 02 0
R 801 00 1 01 0
I 000 02 0 00 0
R 801 00 0 00 0
R 802 00 0 00 0
R 803 00 0 00 0
# CPU ready and reset
W 800 01 0 00 0
P 000 00 0 01 0
R 800 00 0 01 0
# Video mode and mask, graphics bit follows the input
W 801 0F 0 00 0
P 000 00 0 1D 0
I 000 01 0 00 0
R 801 00 0 0E 0
I 000 02 1 00 0
R 801 00 1 0F 0
W 801 0A 1 00 1
R 801 00 1 0A 0
I 000 01 1 00 0
R 801 00 1 0B 0
P 000 00 1 15 0
# RAM scatter including both ends of the window
W 000 00 1 00 2
W 7FF 00 1 00 2
W 123 00 1 00 2
W 456 00 1 00 2
W 2AA 00 1 00 2
W 555 00 1 00 2
W 3C0 A5 1 00 0
R 7FF 00 1 00 0
R 000 00 1 00 0
R 456 00 1 00 0
R 3C0 00 1 00 0
R 123 00 1 00 0
R 555 00 1 00 0
R 2AA 00 1 00 0
# Registers after RAM traffic
P 000 00 1 15 0
R 800 00 1 01 0
R 801 00 1 0B 0
# Back-to-back strobes, RAM and registers interleaved
W 010 00 1 00 3
R 800 00 1 01 1
R 010 00 1 00 1
R 801 00 1 0B 1
W 802 5A 1 00 1
R 7FF 00 1 00 1
R 802 00 1 5A 0
W 020 00 1 00 3
R 020 00 1 00 1
R 000 00 1 00 1
R 803 00 1 00 0
P 000 00 1 15 0

//--- sim/tb_pet_bus.sv
/*
 * Runs sim/bus_patterns.txt against pet_bus_top, must be started from the project root.
 * RAM reads compare against a scoreboard, register reads and pins against the file.
 */

`timescale 1ns/1ns

module tb_pet_bus import pet_bus_pkg::*; ();

    localparam int    CLK_HALF        = 4;
    localparam int    RESET_CYCLES    = 3;
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    ACK_WAIT        = 8;
    localparam string PATTERN_FILE    = "sim/bus_patterns.txt";

    // One operation from the pattern file
    typedef struct packed {
        logic [15:0]              line_no;
        logic [7:0]               op;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    data;
        logic                     gfx;
        logic [DATA_WIDTH-1:0]    exp;
        logic [3:0]               flags;
    } pattern_t;

    // DUT connections
    logic       wb_clock;
    logic       arst_n;
    wb_req_t    wb_req;
    wb_resp_t   wb_resp;
    logic       video_graphic;
    logic       cpu_ready;
    logic       cpu_reset;
    logic       video_col_80_mode;
    logic [1:0] video_ram_mask;

    pattern_t patterns[$];

    // RAM scoreboard where valid marks bytes written during the run
    logic [DATA_WIDTH-1:0] ram_model [0:(2**RAM_ADDR_WIDTH)-1];
    bit                    ram_valid [0:(2**RAM_ADDR_WIDTH)-1];

    int checks;
    int errors;
    int tests;
    int watchdog_cycles;

    pet_bus_top uut (
        .wb_clock_i          (wb_clock),
        .arst_n_i            (arst_n),
        .wb_req_i            (wb_req),
        .wb_resp_o           (wb_resp),
        .video_graphic_i     (video_graphic),
        .cpu_ready_o         (cpu_ready),
        .cpu_reset_o         (cpu_reset),
        .video_col_80_mode_o (video_col_80_mode),
        .video_ram_mask_o    (video_ram_mask)
    );

    always #CLK_HALF wb_clock = ~wb_clock;

    // Parse the pattern file into the queue
    task automatic load_patterns();
        int                       fd;
        int                       fields;
        int                       line_no;
        string                    line;
        logic [7:0]               op;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    data;
        logic                     gfx;
        logic [DATA_WIDTH-1:0]    exp;
        logic [3:0]               flags;
        pattern_t                 p;

        line_no = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("** Error: cannot open pattern file %s", PATTERN_FILE);
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, gfx, exp, flags);
            // Blank line
            if (fields <= 1) begin
                continue;
            end
            if (fields != 6) begin
                $display("** Error: line %0d of %s has %0d fields, expected 6",
                         line_no, PATTERN_FILE, fields);
                errors++;
                continue;
            end
            if (op != "W" && op != "R" && op != "I" && op != "P") begin
                $display("** Error: line %0d of %s has unknown operation %c",
                         line_no, PATTERN_FILE, op);
                errors++;
                continue;
            end
            p.line_no = line_no[15:0];
            p.op      = op;
            p.addr    = addr;
            p.data    = data;
            p.gfx     = gfx;
            p.exp     = exp;
            p.flags   = flags;
            patterns.push_back(p);
        end
        $fclose(fd);
    endtask

    task automatic report_test(input pattern_t p, input int failures);
        tests++;
        if (failures == 0) begin
            $display("line %3d  %c 0x%03h  ok", p.line_no, p.op, p.addr);
        end else begin
            $display("line %3d  %c 0x%03h  FAIL, %0d error(s)", p.line_no, p.op, p.addr, failures);
        end
    endtask

    task automatic show_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] want, input logic [15:0] line_no);
        $display("** Error at %0t ns: %s = 0x%02h, expected 0x%02h (line %0d)",
                 $time, name, got, want, line_no);
        errors++;
    endtask

    // Strobe lines first..last on consecutive cycles and match each ack in order
    task automatic run_bus_group(input int first, input int last);
        int                        count;
        int                        cyc;
        int                        acked;
        int                        mark;
        int                        k;
        int                        rand_word;
        logic                      is_ram;
        logic [RAM_ADDR_WIDTH-1:0] ram_addr;
        pattern_t                  p;
        pattern_t                  done_p;
        wb_req_t                   req;
        logic [DATA_WIDTH-1:0]     exp_q[$];
        bit                        read_q[$];
        bit                        known_q[$];

        count = last - first + 1;
        cyc   = 0;
        acked = 0;
        while (acked < count && cyc < count + ACK_WAIT) begin
            @(posedge wb_clock);
            if (cyc < count) begin
                p          = patterns[first + cyc];
                req.addr   = p.addr;
                req.data   = p.data;
                req.we     = (p.op == "W");
                req.cycle  = 1'b1;
                req.strobe = 1'b1;
                if (req.we && p.flags[1]) begin
                    rand_word = $urandom;
                    req.data  = rand_word[DATA_WIDTH-1:0];
                end
                // Bit 11 low means the RAM window
                is_ram   = !p.addr[REG_SELECT_BIT];
                ram_addr = p.addr[RAM_ADDR_WIDTH-1:0];
                if (req.we) begin
                    read_q.push_back(1'b0);
                    exp_q.push_back('0);
                    known_q.push_back(1'b1);
                    if (is_ram) begin
                        ram_model[ram_addr] = req.data;
                        ram_valid[ram_addr] = 1'b1;
                    end
                end else if (is_ram) begin
                    read_q.push_back(1'b1);
                    exp_q.push_back(ram_model[ram_addr]);
                    known_q.push_back(ram_valid[ram_addr]);
                end else begin
                    read_q.push_back(1'b1);
                    exp_q.push_back(p.exp);
                    known_q.push_back(1'b1);
                end
                wb_req        <= req;
                video_graphic <= p.gfx;
            end else begin
                wb_req <= '0;
            end
            @(negedge wb_clock);
            if (wb_resp.ack) begin
                done_p = patterns[first + acked];
                mark   = errors;
                checks++;
                // Strobe of item n went out at cycle n
                if (cyc - acked != 1) begin
                    $display("** Error at %0t ns: wb_resp_o.ack latency = %0d, expected 1 (line %0d)",
                             $time, cyc - acked, done_p.line_no);
                    errors++;
                end
                // Stall stays low even while the next strobe is on the bus
                checks++;
                if (wb_resp.stall !== 1'b0) begin
                    show_mismatch("wb_resp_o.stall", {7'd0, wb_resp.stall}, 8'd0,
                                  done_p.line_no);
                end
                if (read_q[acked]) begin
                    checks++;
                    if (!known_q[acked]) begin
                        $display("** Error at %0t ns: line %0d reads RAM at 0x%03h before any write",
                                 $time, done_p.line_no, done_p.addr);
                        errors++;
                    end else if (wb_resp.data !== exp_q[acked]) begin
                        show_mismatch("wb_resp_o.data", wb_resp.data, exp_q[acked], done_p.line_no);
                    end
                end
                report_test(done_p, errors - mark);
                acked++;
            end
            cyc++;
        end

        // Items that never saw an ack
        for (k = acked; k < count; k++) begin
            $display("** Error at %0t ns: no ack for line %0d within %0d cycles",
                     $time, patterns[first + k].line_no, count + ACK_WAIT);
            errors++;
            report_test(patterns[first + k], 1);
        end

        // One ack per strobe, so the bus goes quiet next
        @(posedge wb_clock);
        wb_req <= '0;
        @(negedge wb_clock);
        checks++;
        if (wb_resp.ack !== 1'b0) begin
            $display("** Error at %0t ns: wb_resp_o.ack = %0b after the last ack, expected 0",
                     $time, wb_resp.ack);
            errors++;
        end
    endtask

    task automatic run_idle(input pattern_t p);
        int n;

        n = int'(p.data);
        repeat (n) begin
            @(posedge wb_clock);
            wb_req        <= '0;
            video_graphic <= p.gfx;
        end
        report_test(p, 0);
    endtask

    // Expected pins packed as {mask[1:0], col80, cpu_reset, cpu_ready}
    task automatic check_pins(input pattern_t p);
        int mark;

        @(posedge wb_clock);
        wb_req        <= '0;
        video_graphic <= p.gfx;
        @(negedge wb_clock);
        mark = errors;
        checks++;
        if (cpu_ready !== p.exp[0]) begin
            show_mismatch("cpu_ready_o", {7'd0, cpu_ready}, {7'd0, p.exp[0]}, p.line_no);
        end
        checks++;
        if (cpu_reset !== p.exp[1]) begin
            show_mismatch("cpu_reset_o", {7'd0, cpu_reset}, {7'd0, p.exp[1]}, p.line_no);
        end
        checks++;
        if (video_col_80_mode !== p.exp[2]) begin
            show_mismatch("video_col_80_mode_o", {7'd0, video_col_80_mode}, {7'd0, p.exp[2]},
                          p.line_no);
        end
        checks++;
        if (video_ram_mask !== p.exp[4:3]) begin
            show_mismatch("video_ram_mask_o", {6'd0, video_ram_mask}, {6'd0, p.exp[4:3]},
                          p.line_no);
        end
        report_test(p, errors - mark);
    endtask

    // Main sequence
    initial begin
        int       idx;
        int       last;
        pattern_t p;

        wb_clock = 1'b0;
        arst_n        <= 1'b0;
        wb_req        <= '0;
        video_graphic <= 1'b0;
        checks = 0;
        errors = 0;
        tests  = 0;
        void'($urandom(32'h1809eb87));

        load_patterns();
        if (patterns.size() == 0) begin
            $display("** Error: no operations found in %s", PATTERN_FILE);
            errors++;
        end
        watchdog_cycles = (patterns.size() + 1) * CYCLES_PER_LINE + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge wb_clock);
        arst_n <= 1'b1;

        idx = 0;
        while (idx < patterns.size()) begin
            p = patterns[idx];
            case (p.op)
                "W", "R": begin
                    // Gather lines chained by flag bit 0
                    last = idx;
                    while (patterns[last].flags[0] && last + 1 < patterns.size()
                           && (patterns[last + 1].op == "W" || patterns[last + 1].op == "R")) begin
                        last++;
                    end
                    run_bus_group(idx, last);
                    idx = last;
                end
                "I": run_idle(p);
                default: check_pins(p);
            endcase
            idx++;
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog armed once the pattern count is known
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge wb_clock);
        $display("** Error at %0t ns: run did not finish within %0d cycles",
                 $time, watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- src/pet_bus_pkg.sv
/*
 * Shared widths, register map and Wishbone B4 pipelined bus structs.
 * Register window at address bit 11 set, 2 KB RAM window below it.
 */

package pet_bus_pkg;

    // Bus geometry
    localparam int DATA_WIDTH     = 8;
    localparam int WB_ADDR_WIDTH  = 12;
    localparam int RAM_ADDR_WIDTH = 11;
    localparam int REG_ADDR_WIDTH = 2;
    localparam int REG_COUNT      = 4;

    // 1 selects the register file, 0 selects the RAM
    localparam int REG_SELECT_BIT = 11;

    // Register indices with two free scratch bytes at the top
    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        REG_CPU       = 2'd0,
        REG_VIDEO     = 2'd1,
        REG_SCRATCH_0 = 2'd2,
        REG_SCRATCH_1 = 2'd3
    } reg_index_t;

    // REG_CPU bits
    localparam int REG_CPU_READY_BIT = 0;
    localparam int REG_CPU_RESET_BIT = 1;

    // REG_VIDEO bits
    // Graphics bit follows VIA CA2 (0 = graphics, 1 = text)
    localparam int REG_VIDEO_GRAPHICS_BIT = 0;
    localparam int REG_VIDEO_COL_80_BIT   = 1;
    localparam int REG_VIDEO_RAM_MASK_LSB = 2;
    localparam int REG_VIDEO_RAM_MASK_MSB = 3;

    // Power-on state
    // CPU held in reset and not ready
    localparam logic [DATA_WIDTH-1:0] REG_CPU_RESET_VALUE   = 8'h02;
    // 40 columns, graphics, no RAM mask
    localparam logic [DATA_WIDTH-1:0] REG_VIDEO_RESET_VALUE = 8'h00;

    // 23-bit request from the bus master
    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    data;
        logic                     we;
        logic                     cycle;
        logic                     strobe;
    } wb_req_t;

    // 10-bit response from a peripheral
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  stall;
        logic                  ack;
    } wb_resp_t;

endpackage

//--- src/pet_bus_top.sv
/*
 * Bus subsystem top, one Wishbone B4 pipelined port with one-cycle strobe-to-ack latency.
 * Registers live at 0x800-0xFFF (aliased every 4 bytes), RAM at 0x000-0x7FF.
 */

`timescale 1ns/1ns

module pet_bus_top import pet_bus_pkg::*; (
    input  logic       wb_clock_i,
    input  logic       arst_n_i,

    // External bus master
    input  wb_req_t    wb_req_i,
    output wb_resp_t   wb_resp_o,

    // VIA CA2 status
    input  logic       video_graphic_i,

    // System pins
    output logic       cpu_ready_o,
    output logic       cpu_reset_o,
    output logic       video_col_80_mode_o,
    output logic [1:0] video_ram_mask_o
);

    // Decoder selects
    logic     reg_sel;
    logic     ram_sel;

    // Peripheral responses into the merge
    wb_resp_t reg_resp;
    wb_resp_t ram_resp;

    // Address decode and response merge
    wb_address_decoder decoder (
        .wb_clock_i (wb_clock_i),
        .arst_n_i   (arst_n_i),
        .wb_req_i   (wb_req_i),
        .reg_sel_o  (reg_sel),
        .ram_sel_o  (ram_sel),
        .reg_resp_i (reg_resp),
        .ram_resp_i (ram_resp),
        .wb_resp_o  (wb_resp_o)
    );

    // Control and status registers
    // Request is shared, the select qualifies it
    register_file registers (
        .wb_clock_i          (wb_clock_i),
        .arst_n_i            (arst_n_i),
        .wb_req_i            (wb_req_i),
        .wb_sel_i            (reg_sel),
        .wb_resp_o           (reg_resp),
        .video_graphic_i     (video_graphic_i),
        .cpu_ready_o         (cpu_ready_o),
        .cpu_reset_o         (cpu_reset_o),
        .video_col_80_mode_o (video_col_80_mode_o),
        .video_ram_mask_o    (video_ram_mask_o)
    );

    // 2 KB RAM window
    wb_ram ram (
        .wb_clock_i (wb_clock_i),
        .arst_n_i   (arst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_sel_i   (ram_sel),
        .wb_resp_o  (ram_resp)
    );

endmodule

//--- src/register_file.sv
/*
 * Four byte registers behind a Wishbone B4 pipelined port, ack one cycle after strobe.
 * Graphics status bit is reloaded from video_graphic_i on every idle cycle.
 */

`timescale 1ns/1ns

module register_file import pet_bus_pkg::*; (
    // Wishbone peripheral side
    input  logic       wb_clock_i,
    input  logic       arst_n_i,
    input  wb_req_t    wb_req_i,
    input  logic       wb_sel_i,          // From the address decoder
    output wb_resp_t   wb_resp_o,

    // Status input from the VIA
    input  logic       video_graphic_i,

    // CPU control
    output logic       cpu_ready_o,
    output logic       cpu_reset_o,

    // Video control
    output logic       video_col_80_mode_o,
    output logic [1:0] video_ram_mask_o
);

    // Register bank
    logic [REG_COUNT-1:0][DATA_WIDTH-1:0] regs;

    logic                  ack_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  access;
    reg_index_t            reg_idx;

    // Strobe addressed to this block
    assign access  = wb_sel_i & wb_req_i.cycle & wb_req_i.strobe;

    // Low address bits pick the register, upper bits alias
    assign reg_idx = reg_index_t'(wb_req_i.addr[REG_ADDR_WIDTH-1:0]);

    // Control registers and ack
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs[REG_CPU]       <= REG_CPU_RESET_VALUE;
            regs[REG_VIDEO]     <= REG_VIDEO_RESET_VALUE;
            regs[REG_SCRATCH_0] <= '0;
            regs[REG_SCRATCH_1] <= '0;
            ack_q               <= 1'b0;
        end else if (access) begin
            if (wb_req_i.we) begin
                regs[reg_idx] <= wb_req_i.data;
            end
            ack_q <= 1'b1;
        end else begin
            ack_q <= 1'b0;
            // No strobe this cycle so the status bit follows the VIA
            regs[REG_VIDEO][REG_VIDEO_GRAPHICS_BIT] <= video_graphic_i;
        end
    end

    // Read data
    // Old contents are returned when a write lands in the same cycle
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            rdata_q <= regs[reg_idx];
        end
    end

    // Single-cycle peripheral that never stalls
    always_comb begin
        wb_resp_o.data  = rdata_q;
        wb_resp_o.stall = 1'b0;
        wb_resp_o.ack   = ack_q;
    end

    // Pin decode
    assign cpu_ready_o         = regs[REG_CPU][REG_CPU_READY_BIT];
    assign cpu_reset_o         = regs[REG_CPU][REG_CPU_RESET_BIT];
    assign video_col_80_mode_o = regs[REG_VIDEO][REG_VIDEO_COL_80_BIT];
    assign video_ram_mask_o    = regs[REG_VIDEO][REG_VIDEO_RAM_MASK_MSB:REG_VIDEO_RAM_MASK_LSB];

endmodule

//--- src/wb_address_decoder.sv
/*
 * Splits the 12-bit bus into register and RAM windows on address bit 11.
 * Peripherals must ack exactly one cycle after strobe for the data mux to line up.
 */

`timescale 1ns/1ns

module wb_address_decoder import pet_bus_pkg::*; (
    input  logic     wb_clock_i,
    input  logic     arst_n_i,

    // Request from the bus master
    input  wb_req_t  wb_req_i,

    // Peripheral selects
    output logic     reg_sel_o,
    output logic     ram_sel_o,

    // Peripheral responses
    input  wb_resp_t reg_resp_i,
    input  wb_resp_t ram_resp_i,

    // Merged response to the bus master
    output wb_resp_t wb_resp_o
);

    logic strobe_accepted;
    logic reg_selected;

    // Target of the strobe that is due to ack next cycle
    logic resp_from_reg_q;

    assign reg_selected = wb_req_i.addr[REG_SELECT_BIT];

    // Exactly one target is selected for every address
    assign reg_sel_o = reg_selected;
    assign ram_sel_o = ~reg_selected;

    // Stall is never raised, so any strobe inside a cycle is taken
    assign strobe_accepted = wb_req_i.cycle & wb_req_i.strobe & ~wb_resp_o.stall;

    // Remember the target for the ack cycle
    // Holds its value between strobes
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_from_reg_q <= 1'b0;
        end else if (strobe_accepted) begin
            resp_from_reg_q <= reg_selected;
        end
    end

    // Response merge
    always_comb begin
        // Only one peripheral can ack in a given cycle
        wb_resp_o.ack   = reg_resp_i.ack | ram_resp_i.ack;
        wb_resp_o.stall = reg_resp_i.stall | ram_resp_i.stall;

        // Data comes from whichever block was strobed last cycle
        if (resp_from_reg_q) begin
            wb_resp_o.data = reg_resp_i.data;
        end else begin
            wb_resp_o.data = ram_resp_i.data;
        end
    end

endmodule

//--- src/wb_ram.sv
/*
 * 2 KB byte RAM on a Wishbone B4 pipelined port with registered read and one-cycle ack.
 * Contents are undefined after power-up, reset clears only the ack.
 */

`timescale 1ns/1ns

module wb_ram import pet_bus_pkg::*; (
    input  logic     wb_clock_i,
    input  logic     arst_n_i,
    input  wb_req_t  wb_req_i,
    input  logic     wb_sel_i,      // From the address decoder
    output wb_resp_t wb_resp_o
);

    // Storage array
    logic [DATA_WIDTH-1:0] mem [0:(2**RAM_ADDR_WIDTH)-1];

    logic [RAM_ADDR_WIDTH-1:0] word_addr;
    logic [DATA_WIDTH-1:0]     rdata_q;
    logic                      ack_q;
    logic                      access;

    assign access    = wb_sel_i & wb_req_i.cycle & wb_req_i.strobe;
    assign word_addr = wb_req_i.addr[RAM_ADDR_WIDTH-1:0];

    // Read before write on the same port
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            rdata_q <= mem[word_addr];
            if (wb_req_i.we) begin
                mem[word_addr] <= wb_req_i.data;
            end
        end
    end

    // Ack follows each accepted strobe by one cycle
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_comb begin
        wb_resp_o.data  = rdata_q;
        wb_resp_o.stall = 1'b0;
        wb_resp_o.ack   = ack_q;
    end

endmodule
